/* hdl/rv_decode_pkg.sv */
// RV64 decode definitions
package rv_decode_pkg;

  typedef logic [31:0] instr_t;
  typedef logic [63:0] dword_t;
  typedef logic [6:0]  opcode_t;

  // Major opcodes
  localparam opcode_t op_op       = 7'b0110011;
  localparam opcode_t op_op32     = 7'b0111011;
  localparam opcode_t op_imm      = 7'b0010011;
  localparam opcode_t op_imm32    = 7'b0011011;
  localparam opcode_t op_lui      = 7'b0110111;
  localparam opcode_t op_auipc    = 7'b0010111;
  localparam opcode_t op_jal      = 7'b1101111;
  localparam opcode_t op_jalr     = 7'b1100111;
  localparam opcode_t op_branch   = 7'b1100011;
  localparam opcode_t op_load     = 7'b0000011;
  localparam opcode_t op_store    = 7'b0100011;
  localparam opcode_t op_misc_mem = 7'b0001111;
  localparam opcode_t op_system   = 7'b1110011;

  localparam logic [6:0] funct7_base   = 7'b0000000;
  localparam logic [6:0] funct7_alt    = 7'b0100000;
  localparam logic [6:0] funct7_muldiv = 7'b0000001;

  localparam logic [2:0] f3_add_sub = 3'b000;
  localparam logic [2:0] f3_sll     = 3'b001;
  localparam logic [2:0] f3_slt     = 3'b010;
  localparam logic [2:0] f3_sltu    = 3'b011;
  localparam logic [2:0] f3_xor     = 3'b100;
  localparam logic [2:0] f3_srl_sra = 3'b101;
  localparam logic [2:0] f3_or      = 3'b110;
  localparam logic [2:0] f3_and     = 3'b111;

  // M extension without the high-half multiplies
  localparam logic [2:0] f3_mul  = 3'b000;
  localparam logic [2:0] f3_div  = 3'b100;
  localparam logic [2:0] f3_divu = 3'b101;
  localparam logic [2:0] f3_rem  = 3'b110;
  localparam logic [2:0] f3_remu = 3'b111;

  localparam logic [2:0] f3_jalr = 3'b000;
  localparam logic [2:0] f3_beq  = 3'b000;
  localparam logic [2:0] f3_bne  = 3'b001;
  localparam logic [2:0] f3_blt  = 3'b100;
  localparam logic [2:0] f3_bge  = 3'b101;
  localparam logic [2:0] f3_bltu = 3'b110;
  localparam logic [2:0] f3_bgeu = 3'b111;

  localparam logic [2:0] f3_lb  = 3'b000;
  localparam logic [2:0] f3_lh  = 3'b001;
  localparam logic [2:0] f3_lw  = 3'b010;
  localparam logic [2:0] f3_ld  = 3'b011;
  localparam logic [2:0] f3_lbu = 3'b100;
  localparam logic [2:0] f3_lhu = 3'b101;
  localparam logic [2:0] f3_lwu = 3'b110;
  localparam logic [2:0] f3_sb  = 3'b000;
  localparam logic [2:0] f3_sh  = 3'b001;
  localparam logic [2:0] f3_sw  = 3'b010;
  localparam logic [2:0] f3_sd  = 3'b011;

  localparam logic [2:0] f3_fence  = 3'b000;
  localparam logic [2:0] f3_fencei = 3'b001;

  // System function codes in bits 31:20
  localparam logic [11:0] f12_ecall  = 12'h000;
  localparam logic [11:0] f12_ebreak = 12'h001;
  localparam logic [11:0] f12_sret   = 12'h102;
  localparam logic [11:0] f12_wfi    = 12'h105;
  localparam logic [11:0] f12_mret   = 12'h302;

  typedef enum logic [5:0] {
    e_op_none,
    e_op_add, e_op_sub, e_op_sll, e_op_srl, e_op_sra, e_op_slt, e_op_sltu,
    e_op_xor, e_op_or, e_op_and, e_op_pass_src2,
    e_op_mul, e_op_div, e_op_divu, e_op_rem, e_op_remu,
    e_op_jal, e_op_jalr, e_op_beq, e_op_bne, e_op_blt, e_op_bge, e_op_bltu, e_op_bgeu,
    e_op_lb, e_op_lh, e_op_lw, e_op_lbu, e_op_lhu, e_op_lwu, e_op_ld,
    e_op_sb, e_op_sh, e_op_sw, e_op_sd,
    e_op_fencei,
    e_op_mret, e_op_sret, e_op_wfi
  } fu_op_e;

  typedef enum logic {e_src1_is_rs1, e_src1_is_pc} src1_sel_e;
  typedef enum logic {e_src2_is_rs2, e_src2_is_imm} src2_sel_e;
  typedef enum logic {e_baddr_is_pc, e_baddr_is_rs1} baddr_sel_e;

  typedef enum logic [1:0] {
    e_fe_exc_none,
    e_instr_access_fault,
    e_instr_page_fault
  } fe_exc_e;

endpackage

/* hdl/int_op_decoder.sv */
// Integer and multiply class decoder
`timescale 1ns/1ns

module int_op_decoder
  import rv_decode_pkg::*;
(
  input  instr_t    instr_i,
  output logic      hit_o,
  output logic      legal_o,
  output logic      pipe_int_o,
  output logic      pipe_mul_o,
  output logic      pipe_long_o,
  output logic      irf_w_o,
  output logic      opw_o,
  output fu_op_e    fu_op_o,
  output src1_sel_e src1_sel_o,
  output src2_sel_e src2_sel_o
);

  opcode_t    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic       is_reg;
  logic       alt_ok;
  logic       w_ok;
  logic       shift_ok;
  fu_op_e     alu_op;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];
  assign is_reg = (opcode == op_op) || (opcode == op_op32);

  // funct7 alt only exists for SUB and SRA
  assign alt_ok = (funct7 == funct7_base) ||
                  ((funct7 == funct7_alt) && ((funct3 == f3_add_sub) || (funct3 == f3_srl_sra)));
  assign w_ok   = (funct3 == f3_add_sub) || (funct3 == f3_sll) || (funct3 == f3_srl_sra);

  // RV64 shamt is 6 bits in OP-IMM, 5 bits in OP-IMM-32
  assign shift_ok = (opcode == op_imm32)
    ? ((funct7 == funct7_base) || ((funct7 == funct7_alt) && (funct3 == f3_srl_sra)))
    : ((instr_i[31:26] == funct7_base[6:1]) ||
       ((instr_i[31:26] == funct7_alt[6:1]) && (funct3 == f3_srl_sra)));

  always_comb
  begin
    alu_op = e_op_none;
    case (funct3)
      f3_add_sub: alu_op = (is_reg && instr_i[30]) ? e_op_sub : e_op_add;
      f3_sll:     alu_op = e_op_sll;
      f3_slt:     alu_op = e_op_slt;
      f3_sltu:    alu_op = e_op_sltu;
      f3_xor:     alu_op = e_op_xor;
      f3_srl_sra: alu_op = instr_i[30] ? e_op_sra : e_op_srl;
      f3_or:      alu_op = e_op_or;
      f3_and:     alu_op = e_op_and;
    endcase
  end

  always_comb
  begin
    hit_o       = 1'b0;
    legal_o     = 1'b1;
    pipe_int_o  = 1'b0;
    pipe_mul_o  = 1'b0;
    pipe_long_o = 1'b0;
    irf_w_o     = 1'b0;
    opw_o       = (opcode == op_op32) || (opcode == op_imm32);
    fu_op_o     = e_op_none;
    src1_sel_o  = e_src1_is_rs1;
    src2_sel_o  = e_src2_is_rs2;
    case (opcode)
      op_op, op_op32:
      begin
        hit_o = 1'b1;
        if (funct7 == funct7_muldiv)
        begin
          case (funct3)
            f3_mul:  fu_op_o = e_op_mul;
            f3_div:  fu_op_o = e_op_div;
            f3_divu: fu_op_o = e_op_divu;
            f3_rem:  fu_op_o = e_op_rem;
            f3_remu: fu_op_o = e_op_remu;
            default: legal_o = 1'b0;
          endcase
          pipe_mul_o  = (funct3 == f3_mul);
          pipe_long_o = ~pipe_mul_o;
        end
        else
        begin
          pipe_int_o = 1'b1;
          fu_op_o    = alu_op;
          legal_o    = alt_ok && (w_ok || !opw_o);
        end
        // Divides write back late, outside this path
        irf_w_o = ~pipe_long_o;
      end
      op_imm, op_imm32:
      begin
        hit_o      = 1'b1;
        pipe_int_o = 1'b1;
        irf_w_o    = 1'b1;
        fu_op_o    = alu_op;
        src2_sel_o = e_src2_is_imm;
        if ((funct3 == f3_sll) || (funct3 == f3_srl_sra))
          legal_o = shift_ok;
        else
          legal_o = !opw_o || (funct3 == f3_add_sub);
      end
      op_lui:
      begin
        hit_o      = 1'b1;
        pipe_int_o = 1'b1;
        irf_w_o    = 1'b1;
        fu_op_o    = e_op_pass_src2;
        src2_sel_o = e_src2_is_imm;
      end
      op_auipc:
      begin
        hit_o      = 1'b1;
        pipe_int_o = 1'b1;
        irf_w_o    = 1'b1;
        fu_op_o    = e_op_add;
        src1_sel_o = e_src1_is_pc;
        src2_sel_o = e_src2_is_imm;
      end
      default:
      begin
        hit_o = 1'b0;
      end
    endcase
  end

endmodule

/* hdl/ctrl_op_decoder.sv */
// Jump and branch class decoder
`timescale 1ns/1ns

module ctrl_op_decoder
  import rv_decode_pkg::*;
(
  input  instr_t     instr_i,
  output logic       hit_o,
  output logic       legal_o,
  output logic       irf_w_o,
  output fu_op_e     fu_op_o,
  output baddr_sel_e baddr_sel_o
);

  opcode_t    opcode;
  logic [2:0] funct3;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];

  always_comb
  begin
    hit_o       = 1'b0;
    legal_o     = 1'b1;
    irf_w_o     = 1'b0;
    fu_op_o     = e_op_none;
    baddr_sel_o = e_baddr_is_pc;
    case (opcode)
      op_jal:
      begin
        hit_o   = 1'b1;
        irf_w_o = 1'b1;
        fu_op_o = e_op_jal;
      end
      op_jalr:
      begin
        hit_o       = 1'b1;
        irf_w_o     = 1'b1;
        fu_op_o     = e_op_jalr;
        baddr_sel_o = e_baddr_is_rs1;
        legal_o     = (funct3 == f3_jalr);
      end
      op_branch:
      begin
        hit_o = 1'b1;
        case (funct3)
          f3_beq:  fu_op_o = e_op_beq;
          f3_bne:  fu_op_o = e_op_bne;
          f3_blt:  fu_op_o = e_op_blt;
          f3_bge:  fu_op_o = e_op_bge;
          f3_bltu: fu_op_o = e_op_bltu;
          f3_bgeu: fu_op_o = e_op_bgeu;
          default: legal_o = 1'b0;
        endcase
      end
      default:
      begin
        hit_o = 1'b0;
      end
    endcase
  end

endmodule

/* hdl/mem_op_decoder.sv */
// Load, store and fence class decoder
`timescale 1ns/1ns

module mem_op_decoder
  import rv_decode_pkg::*;
(
  input  instr_t instr_i,
  output logic   hit_o,
  output logic   legal_o,
  output logic   irf_w_o,
  output logic   dcache_r_o,
  output logic   dcache_w_o,
  output fu_op_e fu_op_o
);

  opcode_t    opcode;
  logic [2:0] funct3;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];

  always_comb
  begin
    hit_o      = 1'b0;
    legal_o    = 1'b1;
    irf_w_o    = 1'b0;
    dcache_r_o = 1'b0;
    dcache_w_o = 1'b0;
    fu_op_o    = e_op_none;
    case (opcode)
      op_load:
      begin
        hit_o      = 1'b1;
        irf_w_o    = 1'b1;
        dcache_r_o = 1'b1;
        case (funct3)
          f3_lb:   fu_op_o = e_op_lb;
          f3_lh:   fu_op_o = e_op_lh;
          f3_lw:   fu_op_o = e_op_lw;
          f3_ld:   fu_op_o = e_op_ld;
          f3_lbu:  fu_op_o = e_op_lbu;
          f3_lhu:  fu_op_o = e_op_lhu;
          f3_lwu:  fu_op_o = e_op_lwu;
          default: legal_o = 1'b0;
        endcase
      end
      op_store:
      begin
        hit_o      = 1'b1;
        dcache_w_o = 1'b1;
        case (funct3)
          f3_sb:   fu_op_o = e_op_sb;
          f3_sh:   fu_op_o = e_op_sh;
          f3_sw:   fu_op_o = e_op_sw;
          f3_sd:   fu_op_o = e_op_sd;
          default: legal_o = 1'b0;
        endcase
      end
      op_misc_mem:
      begin
        hit_o = 1'b1;
        case (funct3)
          // Plain FENCE retires as a no-op
          f3_fence:  fu_op_o = e_op_none;
          f3_fencei: fu_op_o = e_op_fencei;
          default:   legal_o = 1'b0;
        endcase
      end
      default:
      begin
        hit_o = 1'b0;
      end
    endcase
  end

endmodule

/* hdl/imm_extractor.sv */
// Immediate select and sign extend
`timescale 1ns/1ns

module imm_extractor
  import rv_decode_pkg::*;
(
  input  instr_t instr_i,
  output dword_t imm_o
);

  opcode_t opcode;
  logic    sign;

  assign opcode = instr_i[6:0];
  assign sign   = instr_i[31];

  always_comb
  begin
    case (opcode)
      // U type
      op_lui, op_auipc:
        imm_o = {{32{sign}}, instr_i[31:12], 12'b0};
      // J type
      op_jal:
        imm_o = {{44{sign}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};
      // B type
      op_branch:
        imm_o = {{52{sign}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
      // S type
      op_store:
        imm_o = {{53{sign}}, instr_i[30:25], instr_i[11:7]};
      // I type
      op_jalr, op_load, op_imm, op_imm32:
        imm_o = {{53{sign}}, instr_i[30:20]};
      default:
        imm_o = '0;
    endcase
  end

endmodule

/* hdl/decode_resolve.sv */
// Decode merge, exception priority and output register
`timescale 1ns/1ns

module decode_resolve
  import rv_decode_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       valid_i,
  input  logic       interrupt_i,
  input  fe_exc_e    fe_exc_i,
  input  instr_t     instr_i,
  input  logic       int_hit_i,
  input  logic       int_legal_i,
  input  logic       int_pipe_int_i,
  input  logic       int_pipe_mul_i,
  input  logic       int_pipe_long_i,
  input  logic       int_irf_w_i,
  input  logic       int_opw_i,
  input  fu_op_e     int_fu_op_i,
  input  src1_sel_e  int_src1_sel_i,
  input  src2_sel_e  int_src2_sel_i,
  input  logic       ctrl_hit_i,
  input  logic       ctrl_legal_i,
  input  logic       ctrl_irf_w_i,
  input  fu_op_e     ctrl_fu_op_i,
  input  baddr_sel_e ctrl_baddr_sel_i,
  input  logic       mem_hit_i,
  input  logic       mem_legal_i,
  input  logic       mem_irf_w_i,
  input  logic       mem_dcache_r_i,
  input  logic       mem_dcache_w_i,
  input  fu_op_e     mem_fu_op_i,
  input  dword_t     imm_i,
  output logic       valid_o,
  output logic       pipe_int_o,
  output logic       pipe_mul_o,
  output logic       pipe_long_o,
  output logic       pipe_ctl_o,
  output logic       pipe_mem_o,
  output logic       pipe_sys_o,
  output logic       irf_w_o,
  output logic       dcache_r_o,
  output logic       dcache_w_o,
  output logic       opw_o,
  output fu_op_e     fu_op_o,
  output src1_sel_e  src1_sel_o,
  output src2_sel_e  src2_sel_o,
  output baddr_sel_e baddr_sel_o,
  output dword_t     imm_o,
  output logic       illegal_instr_o,
  output logic       ecall_o,
  output logic       ebreak_o,
  output logic       interrupt_o,
  output logic       instr_access_fault_o,
  output logic       instr_page_fault_o
);

  logic       sys_hit;
  logic       sys_legal;
  logic       sys_ecall;
  logic       sys_ebreak;
  fu_op_e     sys_fu_op;
  logic       illegal;
  logic       kill;
  logic [11:0] dec_d;
  logic [11:0] dec_q;
  logic [3:0] exc_d;
  logic [3:0] exc_q;
  fu_op_e     fu_op_d;
  src1_sel_e  src1_sel_d;
  src2_sel_e  src2_sel_d;
  baddr_sel_e baddr_sel_d;

  assign sys_hit = (instr_i[6:0] == op_system);

  // Only the privileged forms, with funct3, rs1 and rd all zero
  always_comb
  begin
    sys_legal  = (instr_i[19:7] == '0);
    sys_ecall  = 1'b0;
    sys_ebreak = 1'b0;
    sys_fu_op  = e_op_none;
    case (instr_i[31:20])
      f12_ecall:  sys_ecall  = sys_hit;
      f12_ebreak: sys_ebreak = sys_hit;
      f12_mret:   sys_fu_op  = sys_hit ? e_op_mret : e_op_none;
      f12_sret:   sys_fu_op  = sys_hit ? e_op_sret : e_op_none;
      f12_wfi:    sys_fu_op  = sys_hit ? e_op_wfi : e_op_none;
      default:    sys_legal  = 1'b0;
    endcase
  end

  assign illegal = !(int_hit_i || ctrl_hit_i || mem_hit_i || sys_hit) ||
                   (int_hit_i && !int_legal_i) ||
                   (ctrl_hit_i && !ctrl_legal_i) ||
                   (mem_hit_i && !mem_legal_i) ||
                   (sys_hit && !sys_legal);

  assign kill = !valid_i || interrupt_i || (fe_exc_i != e_fe_exc_none) || illegal;

  always_comb
  begin
    // Classes that miss drive zeros, so a plain OR picks the hit
    dec_d = {int_pipe_int_i, int_pipe_mul_i, int_pipe_long_i, ctrl_hit_i,
             mem_hit_i && (mem_fu_op_i != e_op_none), sys_hit,
             int_irf_w_i | ctrl_irf_w_i | mem_irf_w_i,
             mem_dcache_r_i, mem_dcache_w_i, int_opw_i, sys_ecall, sys_ebreak};
    fu_op_d     = fu_op_e'(int_fu_op_i | ctrl_fu_op_i | mem_fu_op_i | sys_fu_op);
    src1_sel_d  = int_src1_sel_i;
    src2_sel_d  = int_src2_sel_i;
    baddr_sel_d = ctrl_baddr_sel_i;
    exc_d       = 4'b0000;
    if (kill)
    begin
      dec_d       = '0;
      fu_op_d     = e_op_none;
      src1_sel_d  = e_src1_is_rs1;
      src2_sel_d  = e_src2_is_rs2;
      baddr_sel_d = e_baddr_is_pc;
    end
    // {illegal, interrupt, access fault, page fault}
    if (valid_i)
    begin
      if (interrupt_i)
        exc_d = 4'b0100;
      else if (fe_exc_i != e_fe_exc_none)
        exc_d = {2'b00, fe_exc_i == e_instr_access_fault, fe_exc_i == e_instr_page_fault};
      else if (illegal)
        exc_d = 4'b1000;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      valid_o     <= 1'b0;
      dec_q       <= '0;
      exc_q       <= '0;
      fu_op_o     <= e_op_none;
      src1_sel_o  <= e_src1_is_rs1;
      src2_sel_o  <= e_src2_is_rs2;
      baddr_sel_o <= e_baddr_is_pc;
      imm_o       <= '0;
    end
    else
    begin
      valid_o     <= valid_i;
      dec_q       <= dec_d;
      exc_q       <= exc_d;
      fu_op_o     <= fu_op_d;
      src1_sel_o  <= src1_sel_d;
      src2_sel_o  <= src2_sel_d;
      baddr_sel_o <= baddr_sel_d;
      imm_o       <= imm_i;
    end
  end

  assign {pipe_int_o, pipe_mul_o, pipe_long_o, pipe_ctl_o, pipe_mem_o, pipe_sys_o,
          irf_w_o, dcache_r_o, dcache_w_o, opw_o, ecall_o, ebreak_o} = dec_q;
  assign {illegal_instr_o, interrupt_o, instr_access_fault_o, instr_page_fault_o} = exc_q;

endmodule

/* hdl/instr_decoder.sv */
// RV64 registered decode stage
`timescale 1ns/1ns

module instr_decoder
  import rv_decode_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       valid_i,
  input  instr_t     instr_i,
  input  logic       interrupt_i,
  input  fe_exc_e    fe_exc_i,
  output logic       valid_o,
  output logic       pipe_int_o,
  output logic       pipe_mul_o,
  output logic       pipe_long_o,
  output logic       pipe_ctl_o,
  output logic       pipe_mem_o,
  output logic       pipe_sys_o,
  output logic       irf_w_o,
  output logic       dcache_r_o,
  output logic       dcache_w_o,
  output logic       opw_o,
  output fu_op_e     fu_op_o,
  output src1_sel_e  src1_sel_o,
  output src2_sel_e  src2_sel_o,
  output baddr_sel_e baddr_sel_o,
  output dword_t     imm_o,
  output logic       illegal_instr_o,
  output logic       ecall_o,
  output logic       ebreak_o,
  output logic       interrupt_o,
  output logic       instr_access_fault_o,
  output logic       instr_page_fault_o
);

  logic       int_hit, int_legal, int_pipe_int, int_pipe_mul, int_pipe_long;
  logic       int_irf_w, int_opw;
  fu_op_e     int_fu_op;
  src1_sel_e  int_src1_sel;
  src2_sel_e  int_src2_sel;
  logic       ctrl_hit, ctrl_legal, ctrl_irf_w;
  fu_op_e     ctrl_fu_op;
  baddr_sel_e ctrl_baddr_sel;
  logic       mem_hit, mem_legal, mem_irf_w, mem_dcache_r, mem_dcache_w;
  fu_op_e     mem_fu_op;
  dword_t     imm;

  int_op_decoder u_int_op_decoder (
    .instr_i     (instr_i),
    .hit_o       (int_hit),
    .legal_o     (int_legal),
    .pipe_int_o  (int_pipe_int),
    .pipe_mul_o  (int_pipe_mul),
    .pipe_long_o (int_pipe_long),
    .irf_w_o     (int_irf_w),
    .opw_o       (int_opw),
    .fu_op_o     (int_fu_op),
    .src1_sel_o  (int_src1_sel),
    .src2_sel_o  (int_src2_sel)
  );

  ctrl_op_decoder u_ctrl_op_decoder (
    .instr_i     (instr_i),
    .hit_o       (ctrl_hit),
    .legal_o     (ctrl_legal),
    .irf_w_o     (ctrl_irf_w),
    .fu_op_o     (ctrl_fu_op),
    .baddr_sel_o (ctrl_baddr_sel)
  );

  mem_op_decoder u_mem_op_decoder (
    .instr_i    (instr_i),
    .hit_o      (mem_hit),
    .legal_o    (mem_legal),
    .irf_w_o    (mem_irf_w),
    .dcache_r_o (mem_dcache_r),
    .dcache_w_o (mem_dcache_w),
    .fu_op_o    (mem_fu_op)
  );

  imm_extractor u_imm_extractor (
    .instr_i (instr_i),
    .imm_o   (imm)
  );

  decode_resolve u_decode_resolve (
    .clk_i                (clk_i),
    .rst_n_i              (rst_n_i),
    .valid_i              (valid_i),
    .interrupt_i          (interrupt_i),
    .fe_exc_i             (fe_exc_i),
    .instr_i              (instr_i),
    .int_hit_i            (int_hit),
    .int_legal_i          (int_legal),
    .int_pipe_int_i       (int_pipe_int),
    .int_pipe_mul_i       (int_pipe_mul),
    .int_pipe_long_i      (int_pipe_long),
    .int_irf_w_i          (int_irf_w),
    .int_opw_i            (int_opw),
    .int_fu_op_i          (int_fu_op),
    .int_src1_sel_i       (int_src1_sel),
    .int_src2_sel_i       (int_src2_sel),
    .ctrl_hit_i           (ctrl_hit),
    .ctrl_legal_i         (ctrl_legal),
    .ctrl_irf_w_i         (ctrl_irf_w),
    .ctrl_fu_op_i         (ctrl_fu_op),
    .ctrl_baddr_sel_i     (ctrl_baddr_sel),
    .mem_hit_i            (mem_hit),
    .mem_legal_i          (mem_legal),
    .mem_irf_w_i          (mem_irf_w),
    .mem_dcache_r_i       (mem_dcache_r),
    .mem_dcache_w_i       (mem_dcache_w),
    .mem_fu_op_i          (mem_fu_op),
    .imm_i                (imm),
    .valid_o              (valid_o),
    .pipe_int_o           (pipe_int_o),
    .pipe_mul_o           (pipe_mul_o),
    .pipe_long_o          (pipe_long_o),
    .pipe_ctl_o           (pipe_ctl_o),
    .pipe_mem_o           (pipe_mem_o),
    .pipe_sys_o           (pipe_sys_o),
    .irf_w_o              (irf_w_o),
    .dcache_r_o           (dcache_r_o),
    .dcache_w_o           (dcache_w_o),
    .opw_o                (opw_o),
    .fu_op_o              (fu_op_o),
    .src1_sel_o           (src1_sel_o),
    .src2_sel_o           (src2_sel_o),
    .baddr_sel_o          (baddr_sel_o),
    .imm_o                (imm_o),
    .illegal_instr_o      (illegal_instr_o),
    .ecall_o              (ecall_o),
    .ebreak_o             (ebreak_o),
    .interrupt_o          (interrupt_o),
    .instr_access_fault_o (instr_access_fault_o),
    .instr_page_fault_o   (instr_page_fault_o)
  );

endmodule

/* tb/instr_decoder_chk.sv */
// Decode stage output checker
`timescale 1ns/1ns

module instr_decoder_chk
(
  input logic       clk_i,
  input logic       rst_n_i,
  input logic       in_valid_i,
  input logic       out_valid_i,
  input logic [5:0] pipe_vec_i,
  input logic       irf_w_i,
  input logic       dcache_r_i,
  input logic       dcache_w_i,
  input logic       illegal_i
);

  a_valid_in_reset: assert property (@(posedge clk_i) !rst_n_i |-> !out_valid_i)
    else $error("valid_o high while reset is active");

  // One cycle of latency on the valid bit
  a_valid_delay: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $past(rst_n_i) |-> (out_valid_i == $past(in_valid_i)))
    else $error("valid_o does not follow valid_i by one cycle");

  a_one_pipe: assert property (@(posedge clk_i) disable iff (!rst_n_i) $onehot0(pipe_vec_i))
    else $error("more than one pipe flag is high");

  a_illegal_quiet: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    illegal_i |-> !(irf_w_i || dcache_r_i || dcache_w_i))
    else $error("illegal instruction with register write or cache access");

endmodule

bind instr_decoder instr_decoder_chk u_chk (
  .clk_i       (clk_i),
  .rst_n_i     (rst_n_i),
  .in_valid_i  (valid_i),
  .out_valid_i (valid_o),
  .pipe_vec_i  ({pipe_int_o, pipe_mul_o, pipe_long_o, pipe_ctl_o, pipe_mem_o, pipe_sys_o}),
  .irf_w_i     (irf_w_o),
  .dcache_r_i  (dcache_r_o),
  .dcache_w_i  (dcache_w_o),
  .illegal_i   (illegal_instr_o)
);

/* tb/instr_decoder_tb.sv */
// RV64 decode stage testbench
`timescale 1ns/1ns

module instr_decoder_tb
  import rv_decode_pkg::*;
();

  // Register field masks that get random values
  localparam logic [31:0] m_none = 32'h00000000;
  localparam logic [31:0] m_r    = 32'h01FF8F80;
  localparam logic [31:0] m_i    = 32'h000F8F80;
  localparam logic [31:0] m_sb   = 32'h01FF8000;
  localparam logic [31:0] m_u    = 32'h00000F80;

  // pipe {int, mul, long, ctl, mem, sys}
  // flags {irf_w, dcache_r, dcache_w, opw, ecall, ebreak}
  // sel {src1, src2, baddr}
  // exc {illegal, interrupt, access fault, page fault}
  typedef struct packed {
    logic [31:0] instr;
    logic [31:0] mask;
    logic        valid;
    logic        irq;
    fe_exc_e     fe;
    logic [5:0]  pipe;
    logic [5:0]  flags;
    logic [2:0]  sel;
    fu_op_e      op;
    logic [3:0]  exc;
  } row_t;

  logic       clk;
  logic       rst_n;
  logic       in_valid;
  instr_t     in_instr;
  logic       in_irq;
  fe_exc_e    in_fe;
  logic       out_valid;
  logic       pipe_int, pipe_mul, pipe_long, pipe_ctl, pipe_mem, pipe_sys;
  logic       irf_w, dcache_r, dcache_w, opw;
  fu_op_e     fu_op;
  src1_sel_e  src1_sel;
  src2_sel_e  src2_sel;
  baddr_sel_e baddr_sel;
  dword_t     imm;
  logic       illegal_instr, ecall, ebreak, interrupt, access_fault, page_fault;

  row_t   rows[$];
  integer seed = 57941;

  instr_decoder UUT (
    .clk_i                (clk),
    .rst_n_i              (rst_n),
    .valid_i              (in_valid),
    .instr_i              (in_instr),
    .interrupt_i          (in_irq),
    .fe_exc_i             (in_fe),
    .valid_o              (out_valid),
    .pipe_int_o           (pipe_int),
    .pipe_mul_o           (pipe_mul),
    .pipe_long_o          (pipe_long),
    .pipe_ctl_o           (pipe_ctl),
    .pipe_mem_o           (pipe_mem),
    .pipe_sys_o           (pipe_sys),
    .irf_w_o              (irf_w),
    .dcache_r_o           (dcache_r),
    .dcache_w_o           (dcache_w),
    .opw_o                (opw),
    .fu_op_o              (fu_op),
    .src1_sel_o           (src1_sel),
    .src2_sel_o           (src2_sel),
    .baddr_sel_o          (baddr_sel),
    .imm_o                (imm),
    .illegal_instr_o      (illegal_instr),
    .ecall_o              (ecall),
    .ebreak_o             (ebreak),
    .interrupt_o          (interrupt),
    .instr_access_fault_o (access_fault),
    .instr_page_fault_o   (page_fault)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial
  begin
    rst_n = 1'b0;
    repeat (5) @(posedge clk);
    #1 rst_n = 1'b1;
  end

  // Sign-extended immediate by instruction format
  function automatic dword_t expected_imm(input instr_t w);
    dword_t v;
    case (w[6:0])
      op_lui, op_auipc: v = 64'($signed({w[31:12], 12'h000}));
      op_jal:           v = 64'($signed({w[31], w[19:12], w[20], w[30:21], 1'b0}));
      op_branch:        v = 64'($signed({w[31], w[7], w[30:25], w[11:8], 1'b0}));
      op_store:         v = 64'($signed({w[31:25], w[11:7]}));
      op_jalr, op_load, op_imm, op_imm32:
                        v = 64'($signed(w[31:20]));
      default:          v = '0;
    endcase
    return v;
  endfunction

  task automatic add_row(input logic [31:0] instr, input logic [31:0] mask, input logic irq,
                         input fe_exc_e fe, input logic [5:0] pipe, input logic [5:0] flags,
                         input logic [2:0] sel, input fu_op_e op, input logic [3:0] exc);
    row_t r;
    r = '{instr: instr, mask: mask, valid: 1'b1, irq: irq, fe: fe, pipe: pipe,
          flags: flags, sel: sel, op: op, exc: exc};
    rows.push_back(r);
  endtask

  // Bubble row with all outputs low except the immediate
  task automatic add_bubble(input logic [31:0] instr, input logic irq, input fe_exc_e fe);
    row_t r;
    r = '0;
    r.instr = instr;
    r.irq   = irq;
    r.fe    = fe;
    rows.push_back(r);
  endtask

  task automatic build_table();
    // Integer group
    add_row(32'h00000033, m_r, 0, e_fe_exc_none, 6'b100000, 6'b100000, 3'b000, e_op_add, 4'b0000);
    add_row(32'h4000003B, m_r, 0, e_fe_exc_none, 6'b100000, 6'b100100, 3'b000, e_op_sub, 4'b0000);
    add_row(32'hFFB00013, m_i, 0, e_fe_exc_none, 6'b100000, 6'b100000, 3'b010, e_op_add, 4'b0000);
    add_row(32'h4070501B, m_i, 0, e_fe_exc_none, 6'b100000, 6'b100100, 3'b010, e_op_sra, 4'b0000);
    add_row(32'h12345037, m_u, 0, e_fe_exc_none, 6'b100000, 6'b100000, 3'b010, e_op_pass_src2,
            4'b0000);
    add_row(32'h80000017, m_u, 0, e_fe_exc_none, 6'b100000, 6'b100000, 3'b110, e_op_add, 4'b0000);
    add_row(32'h02000033, m_r, 0, e_fe_exc_none, 6'b010000, 6'b100000, 3'b000, e_op_mul, 4'b0000);
    add_row(32'h02005033, m_r, 0, e_fe_exc_none, 6'b001000, 6'b000000, 3'b000, e_op_divu, 4'b0000);
    add_row(32'h0200603B, m_r, 0, e_fe_exc_none, 6'b001000, 6'b000100, 3'b000, e_op_rem, 4'b0000);
    // Bubbles in the middle of the stream
    add_bubble(32'h01003003, 1'b0, e_fe_exc_none);
    add_bubble(32'h0000007F, 1'b1, e_instr_page_fault);
    // Jumps, branches, loads, stores, fences
    add_row(32'hA5A5A06F, m_u, 0, e_fe_exc_none, 6'b000100, 6'b100000, 3'b000, e_op_jal, 4'b0000);
    add_row(32'hFF000067, m_i, 0, e_fe_exc_none, 6'b000100, 6'b100000, 3'b001, e_op_jalr, 4'b0000);
    add_row(32'hFE000EE3, m_sb, 0, e_fe_exc_none, 6'b000100, 6'b000000, 3'b000, e_op_beq, 4'b0000);
    add_row(32'h02007463, m_sb, 0, e_fe_exc_none, 6'b000100, 6'b000000, 3'b000, e_op_bgeu, 4'b0000);
    add_row(32'h7FF00003, m_i, 0, e_fe_exc_none, 6'b000010, 6'b110000, 3'b000, e_op_lb, 4'b0000);
    add_row(32'h80006003, m_i, 0, e_fe_exc_none, 6'b000010, 6'b110000, 3'b000, e_op_lwu, 4'b0000);
    add_row(32'h01003003, m_i, 0, e_fe_exc_none, 6'b000010, 6'b110000, 3'b000, e_op_ld, 4'b0000);
    add_row(32'hFE000FA3, m_sb, 0, e_fe_exc_none, 6'b000010, 6'b001000, 3'b000, e_op_sb, 4'b0000);
    add_row(32'h00003423, m_sb, 0, e_fe_exc_none, 6'b000010, 6'b001000, 3'b000, e_op_sd, 4'b0000);
    add_row(32'h0FF0000F, m_i, 0, e_fe_exc_none, 6'b000000, 6'b000000, 3'b000, e_op_none, 4'b0000);
    add_row(32'h0000100F, m_i, 0, e_fe_exc_none, 6'b000010, 6'b000000, 3'b000, e_op_fencei,
            4'b0000);
    // Unknown, FADD.S, FLW, AMOADD.D, SLT in OP-32, bad branch, CSRRW
    add_row(32'h0000007F, m_r, 0, e_fe_exc_none, '0, '0, '0, e_op_none, 4'b1000);
    add_row(32'h00000053, m_r, 0, e_fe_exc_none, '0, '0, '0, e_op_none, 4'b1000);
    add_row(32'h00002007, m_i, 0, e_fe_exc_none, '0, '0, '0, e_op_none, 4'b1000);
    add_row(32'h0000302F, m_r, 0, e_fe_exc_none, '0, '0, '0, e_op_none, 4'b1000);
    add_row(32'h0000203B, m_r, 0, e_fe_exc_none, '0, '0, '0, e_op_none, 4'b1000);
    add_row(32'h00002063, m_sb, 0, e_fe_exc_none, '0, '0, '0, e_op_none, 4'b1000);
    add_row(32'h30001073, m_i, 0, e_fe_exc_none, '0, '0, '0, e_op_none, 4'b1000);
    // System group
    add_row(32'h00000073, m_none, 0, e_fe_exc_none, 6'b000001, 6'b000010, 3'b000, e_op_none,
            4'b0000);
    add_row(32'h00100073, m_none, 0, e_fe_exc_none, 6'b000001, 6'b000001, 3'b000, e_op_none,
            4'b0000);
    add_row(32'h30200073, m_none, 0, e_fe_exc_none, 6'b000001, 6'b000000, 3'b000, e_op_mret,
            4'b0000);
    add_row(32'h10200073, m_none, 0, e_fe_exc_none, 6'b000001, 6'b000000, 3'b000, e_op_sret,
            4'b0000);
    add_row(32'h10500073, m_none, 0, e_fe_exc_none, 6'b000001, 6'b000000, 3'b000, e_op_wfi,
            4'b0000);
    // Exception priority
    add_row(32'h0000007F, m_r, 1, e_instr_access_fault, '0, '0, '0, e_op_none, 4'b0100);
    add_row(32'h0000007F, m_r, 0, e_instr_access_fault, '0, '0, '0, e_op_none, 4'b0010);
    add_row(32'h0000007F, m_r, 0, e_instr_page_fault, '0, '0, '0, e_op_none, 4'b0001);
    add_row(32'h00000033, m_r, 0, e_instr_page_fault, '0, '0, '0, e_op_none, 4'b0001);
    add_row(32'hFFB00013, m_i, 1, e_instr_page_fault, '0, '0, '0, e_op_none, 4'b0100);
    add_row(32'h01003003, m_i, 0, e_instr_access_fault, '0, '0, '0, e_op_none, 4'b0010);
    add_row(32'h00000033, m_r, 0, e_fe_exc_none, 6'b100000, 6'b100000, 3'b000, e_op_add, 4'b0000);
  endtask

  task automatic check_value(input string what, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp)
    begin
      $display("ERR %0t ns: %s is %h, expected %h", $time, what, got, exp);
      $display("Result: FAILED");
      $fatal(1, "decode output mismatch");
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic drive_row(input row_t r, output instr_t applied);
    logic [31:0] rnd;
    rnd      = $random(seed);
    applied  = (r.instr & ~r.mask) | (rnd & r.mask);
    in_valid = r.valid;
    in_instr = applied;
    in_irq   = r.irq;
    in_fe    = r.fe;
  endtask

  task automatic check_row(input int idx, input row_t r, input instr_t applied);
    string tag;
    tag = $sformatf("row %0d instr %h", idx, applied);
    check_value({tag, " valid_o"}, 64'(out_valid), 64'(r.valid));
    check_value({tag, " pipes"},
                64'({pipe_int, pipe_mul, pipe_long, pipe_ctl, pipe_mem, pipe_sys}), 64'(r.pipe));
    check_value({tag, " flags"},
                64'({irf_w, dcache_r, dcache_w, opw, ecall, ebreak}), 64'(r.flags));
    check_value({tag, " selects"}, 64'({src1_sel, src2_sel, baddr_sel}), 64'(r.sel));
    check_value({tag, " fu_op"}, 64'(fu_op), 64'(r.op));
    check_value({tag, " exceptions"},
                64'({illegal_instr, interrupt, access_fault, page_fault}), 64'(r.exc));
    check_value({tag, " imm"}, imm, expected_imm(applied));
  endtask

  initial
  begin
    int     cycles;
    row_t   cleared;
    instr_t applied;
    in_valid = 1'b0;
    in_instr = '0;
    in_irq   = 1'b0;
    in_fe    = e_fe_exc_none;
    cleared  = '0;
    cycles   = 0;
    build_table();

    while (rst_n !== 1'b1)
    begin
      if (cycles == 20)
      begin
        $display("Timeout: reset was never released");
        $display("Result: FAILED");
        $fatal(1, "reset timeout");
      end
      @(posedge clk);
      cycles++;
    end
    #1;

    // Idle outputs after reset
    next_cycle();
    check_row(-1, cleared, '0);

    // One row per cycle with its check on the next edge
    foreach (rows[idx])
    begin
      drive_row(rows[idx], applied);
      next_cycle();
      check_row(idx, rows[idx], applied);
    end
    in_valid = 1'b0;
    in_instr = '0;
    in_irq   = 1'b0;
    in_fe    = e_fe_exc_none;
    next_cycle();
    check_row(rows.size(), cleared, '0);

    $display("Result: PASSED");
    $finish;
  end

endmodule

/* files.f */
hdl/rv_decode_pkg.sv
hdl/int_op_decoder.sv
hdl/ctrl_op_decoder.sv
hdl/mem_op_decoder.sv
hdl/imm_extractor.sv
hdl/decode_resolve.sv
hdl/instr_decoder.sv
tb/instr_decoder_chk.sv
tb/instr_decoder_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= instr_decoder_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns -j 0

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	@grep -qx 'Result: PASSED' $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
